/* files.f */
design/ldbctl_pkg.sv
design/bus_input_sync.sv
design/pal_44302b.sv
design/pal_44303b.sv
design/pal_44304e.sv
design/ldb_output_stage.sv
design/bif_dpath_ldbctl.sv
tests/tb_clock.sv
tests/tb_ldbctl.sv

/* Bender.yml */
package:
  name: bif_dpath_ldbctl

sources:
  - design/ldbctl_pkg.sv
  - design/bus_input_sync.sv
  - design/pal_44302b.sv
  - design/pal_44303b.sv
  - design/pal_44304e.sv
  - design/ldb_output_stage.sv
  - design/bif_dpath_ldbctl.sv
  - target: simulation
    files:
      - tests/tb_clock.sv
      - tests/tb_ldbctl.sv

/* tests/tb_ldbctl.sv */
/* Testbench for the local/bus data-path control block. Drives pins on the falling
   edge, runs a cycle model of the pipeline and compares every output each cycle */
`timescale 1ns/1ps
`default_nettype none

module tb_ldbctl;

   import ldbctl_pkg::*;

   localparam int CLK_PERIOD_NS   = 40;
   localparam int RESET_CYCLES    = 8;
   localparam int DECODE_CYCLES   = 300;   // Random grant/write decode
   localparam int RANDOM_CYCLES   = 2000;  // Long random run
   localparam int DIRECTED_CYCLES = 200;   // Upper bound for directed tests
   localparam int WATCHDOG_NS     = (RESET_CYCLES + DECODE_CYCLES + RANDOM_CYCLES
                                     + DIRECTED_CYCLES) * CLK_PERIOD_NS + 2000;

   logic        clk;
   logic        reset;
   ldb_pins_t   pins;
   ldb_out_t    ldb_out;

   // Model state mirroring the sample registers, the two PAL flops and the outputs
   ldb_sample_t m_smp;
   logic        m_dstb;
   logic        m_bact;
   ldb_out_t    m_out;
   logic        m_both;       // Both directions were requested before the guard
   logic        m_rst;        // Reset seen at the last edge

   logic [31:0] rng;
   int          errors;
   int          checks;
   int          tests_run;
   int          tests_failed;
   int          test_start_errors;
   string       test_name;

   tb_clock #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) u_clock (
      .clk   (clk),
      .reset (reset)
   );

   bif_dpath_ldbctl uut (
      .clk     (clk),
      .reset   (reset),
      .pins    (pins),
      .ldb_out (ldb_out)
   );

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Every pin at its inactive level
   function automatic ldb_pins_t idle_pins();
      ldb_pins_t p;
      p       = '1;        // Active-low pins off
      p.write = 1'b0;
      p.mis0  = 1'b0;
      p.pd1   = 1'b0;
      p.pd3   = 1'b0;
      return p;
   endfunction

   task automatic check_value(input string label, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("FAIL %s/%s: expected %0h, actual %0h", test_name, label, expected, actual);
      end
   endtask

   // Levels mostly hold while a few bits toggle each cycle
   task automatic random_pins(inout ldb_pins_t p, input bit allow_pd);
      for (int i = 0; i < $bits(ldb_pins_t); i++) begin
         rng = xorshift(rng);
         if (rng[3:0] < 4'd3) p[i] = ~p[i];       // About one in five
      end
      rng   = xorshift(rng);
      p.pd1 = allow_pd && (rng[5:0] == 6'd0);     // Test inputs rare
      p.pd3 = allow_pd && (rng[11:6] == 6'd0);
   endtask

   // One clock edge of the reference pipeline
   task automatic model_step(input ldb_pins_t p);
      ldb_ctl_t    c;
      ldb_sample_t s_next;
      logic        cmwrite;
      logic        dstb_next;
      logic        bact_next;
      c.bgnt_cact = m_smp.bgnt && m_smp.cact;
      c.cgnt_cact = m_smp.cgnt && m_smp.cact;
      c.emd       = !m_smp.pd3 && m_smp.cgnt && m_smp.cgnt50 && !m_smp.iorq;
      c.dstb      = m_dstb;
      dstb_next   = !m_smp.pd3 && ((m_smp.bgnt && m_smp.bdry && !m_smp.bdry50)
                                   || (m_dstb && !m_smp.term && !m_smp.rt));
      // Write decode with pd1 forcing the three enables low
      c.cbwrite = m_smp.cact && m_smp.cgnt && m_smp.eadr && m_smp.write && !m_smp.iod;
      cmwrite   = m_smp.cact && !m_smp.cgnt && m_smp.write && !m_smp.mis0;
      c.wbd     = c.cbwrite || (m_bact && !m_smp.binput50);
      c.wlbd    = cmwrite || (m_bact && m_smp.binput50);
      if (m_smp.pd1) begin
         c.cbwrite = 1'b0;
         c.wbd     = 1'b0;
         c.wlbd    = 1'b0;
      end
      bact_next = !m_smp.pd3 && m_smp.bgnt && (m_bact || !m_smp.bgnt50);
      c.dbapr   = m_smp.ibapr && !m_smp.bdap50 && !m_smp.cgnt;
      c.ebadr   = m_smp.cgnt && m_smp.ebus && m_smp.gnt;
      c.ebd     = m_bact || (m_smp.cgnt && m_smp.ebus);
      c.clkbd   = m_bact && !m_smp.mwrite && m_smp.bdap && !m_smp.bdap50;
      m_both    = c.wbd && c.wlbd;
      if (m_both) begin                            // Guard drops both
         c.wbd  = 1'b0;
         c.wlbd = 1'b0;
      end
      // Pins to active high and older copies from the previous sample
      s_next = '{cact: !p.cact_n, cgnt: !p.cgnt_n, bgnt: !p.bgnt_n, gnt: !p.gnt_n,
                 eadr: !p.eadr_n, ebus: !p.ebus_n, iod: !p.iod_n, iorq: !p.iorq_n,
                 write: p.write, mwrite: !p.mwrite_n, mis0: p.mis0,
                 binput: !p.binput_n, bdry: !p.bdry_n, bdap: !p.bdap_n,
                 term: !p.term_n, rt: !p.rt_n, ibapr: !p.ibapr_n, pd1: p.pd1, pd3: p.pd3,
                 bdry50: m_smp.bdry, bgnt50: m_smp.bgnt, cgnt50: m_smp.cgnt,
                 binput50: m_smp.binput, bdap50: m_smp.bdap};
      m_rst = reset;
      if (reset) begin
         m_smp  = '0;
         m_dstb = 1'b0;
         m_bact = 1'b0;
         m_out  = LDB_OUT_RESET;
      end else begin
         m_out  = '{bgntcact: c.bgnt_cact, cgntcact_n: !c.cgnt_cact, emd_n: !c.emd,
                    dstb_n: !c.dstb, cbwrite_n: !c.cbwrite, wbd_n: !c.wbd,
                    wlbd_n: !c.wlbd, dbapr: c.dbapr, ebadr: c.ebadr, clkbd: c.clkbd,
                    ebd_n: !c.ebd};
         m_smp  = s_next;
         m_dstb = dstb_next;
         m_bact = bact_next;
      end
   endtask

   // Starts and ends on a falling edge
   task automatic step_cycle(input ldb_pins_t p);
      pins = p;                    // Settles well before the rising edge
      @(posedge clk);
      model_step(p);
      @(negedge clk);
      check_value("ldb_out", m_out, ldb_out);
   endtask

   task automatic run(input ldb_pins_t p, input int n);
      repeat (n) step_cycle(p);
   endtask

   // Clears any strobe or bus-active state left from random stimulus
   task automatic flush();
      ldb_pins_t p;
      p     = idle_pins();
      p.pd3 = 1'b1;
      run(p, 3);
      run(idle_pins(), 3);
   endtask

   task automatic begin_test(input string name);
      test_name         = name;
      test_start_errors = errors;
   endtask

   task automatic end_test();
      tests_run++;
      if (errors > test_start_errors) tests_failed++;
      $display("test %-14s done, %0d errors", test_name, errors - test_start_errors);
   endtask

   initial begin
      ldb_pins_t p;
      int        pulses;
      rng          = 32'd83801;
      errors       = 0;
      checks       = 0;
      tests_run    = 0;
      tests_failed = 0;
      pins         = idle_pins();
      m_smp        = '0;
      m_dstb       = 1'b0;
      m_bact       = 1'b0;
      m_out        = LDB_OUT_RESET;
      m_both       = 1'b0;
      m_rst        = 1'b1;
      @(negedge clk);

      begin_test("reset");
      p = idle_pins();
      do begin                                     // Last pass is the first edge out of reset
         random_pins(p, 1'b0);
         step_cycle(p);
         check_value("reset value", LDB_OUT_RESET, ldb_out);
      end while (m_rst);
      end_test();

      begin_test("decode");
      repeat (DECODE_CYCLES) begin
         random_pins(p, 1'b0);
         step_cycle(p);
      end
      end_test();

      begin_test("data_strobe");
      flush();
      p        = idle_pins();
      p.bgnt_n = 1'b0;
      run(p, 3);
      p.bdry_n = 1'b0;                             // New bus ready
      run(p, 3);
      check_value("set on ready", 1'b0, ldb_out.dstb_n);
      run(p, 4);
      check_value("held", 1'b0, ldb_out.dstb_n);
      p.term_n = 1'b0;
      run(p, 1);
      p.term_n = 1'b1;
      run(p, 2);
      check_value("cleared by term", 1'b1, ldb_out.dstb_n);
      run(p, 3);
      check_value("no restart", 1'b1, ldb_out.dstb_n);  // Ready still high but not new
      p.bdry_n = 1'b1;
      run(p, 2);
      p.bdry_n = 1'b0;
      run(p, 3);
      check_value("set again", 1'b0, ldb_out.dstb_n);
      p.rt_n = 1'b0;
      run(p, 1);
      p.rt_n = 1'b1;
      run(p, 2);
      check_value("cleared by retry", 1'b1, ldb_out.dstb_n);
      p.bdry_n = 1'b1;
      run(p, 2);
      p.pd3    = 1'b1;
      p.bdry_n = 1'b0;
      run(p, 4);
      check_value("off under pd3", 1'b1, ldb_out.dstb_n);
      p.pd3 = 1'b0;
      run(p, 2);
      end_test();

      begin_test("bus_active");
      flush();
      p          = idle_pins();
      p.binput_n = 1'b0;                           // Bus read
      run(p, 2);
      p.bgnt_n = 1'b0;
      run(p, 3);
      check_value("ebd_n on grant", 1'b0, ldb_out.ebd_n);
      check_value("wlbd_n on read", 1'b0, ldb_out.wlbd_n);
      check_value("wbd_n on read", 1'b1, ldb_out.wbd_n);
      for (int a = 0; a < 2; a++) begin
         pulses   = 0;
         p.bdap_n = 1'b0;
         repeat (6) begin
            step_cycle(p);
            if (ldb_out.clkbd) pulses++;
         end
         check_value("clkbd pulses", 1, pulses);
         p.bdap_n = 1'b1;
         run(p, 3);
      end
      pulses     = 0;
      p.mwrite_n = 1'b0;                           // Write cycle gives no data clock
      p.bdap_n   = 1'b0;
      repeat (6) begin
         step_cycle(p);
         if (ldb_out.clkbd) pulses++;
      end
      check_value("clkbd on write", 0, pulses);
      p.bdap_n   = 1'b1;
      p.mwrite_n = 1'b1;
      p.binput_n = 1'b1;                           // Bus output direction
      run(p, 3);
      check_value("wbd_n on output", 1'b0, ldb_out.wbd_n);
      check_value("wlbd_n on output", 1'b1, ldb_out.wlbd_n);
      p.bgnt_n = 1'b1;
      run(p, 3);
      check_value("ebd_n after grant", 1'b1, ldb_out.ebd_n);
      end_test();

      begin_test("guard_test");
      flush();
      p          = idle_pins();
      p.bgnt_n   = 1'b0;
      p.binput_n = 1'b0;                           // Bus active read asks for local drive
      run(p, 4);
      p.cact_n = 1'b0;
      p.cgnt_n = 1'b0;
      p.eadr_n = 1'b0;
      p.write  = 1'b1;                             // CPU bus write asks for bus drive
      run(p, 2);
      check_value("contention seen", 1'b1, m_both);
      check_value("wbd_n guarded", 1'b1, ldb_out.wbd_n);
      check_value("wlbd_n guarded", 1'b1, ldb_out.wlbd_n);
      p.bgnt_n   = 1'b1;
      p.binput_n = 1'b1;
      run(p, 4);
      check_value("cbwrite_n set", 1'b0, ldb_out.cbwrite_n);
      check_value("wbd_n set", 1'b0, ldb_out.wbd_n);
      p.pd1 = 1'b1;
      run(p, 2);
      check_value("cbwrite_n pd1", 1'b1, ldb_out.cbwrite_n);
      check_value("wbd_n pd1", 1'b1, ldb_out.wbd_n);
      p.pd1    = 1'b0;
      p.cgnt_n = 1'b1;                             // Local write asks for local drive
      run(p, 2);
      check_value("wlbd_n set", 1'b0, ldb_out.wlbd_n);
      p.pd1 = 1'b1;
      run(p, 2);
      check_value("wlbd_n pd1", 1'b1, ldb_out.wlbd_n);
      end_test();

      begin_test("random");
      p = idle_pins();
      repeat (RANDOM_CYCLES) begin
         random_pins(p, 1'b1);
         step_cycle(p);
      end
      end_test();

      $display("Tests: %0d run, %0d failed; checks: %0d, errors: %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
      $display("FAIL: see errors above");
      $finish;
   end

endmodule

`default_nettype wire

/* tests/tb_clock.sv */
/* Testbench clock and reset source. Free-running clock, reset held high for a
   fixed number of cycles and released on a falling edge */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
   parameter int PERIOD_NS    = 40,
   parameter int RESET_CYCLES = 8
) (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;   // 50 percent duty
   end

   initial begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);  // Reset seen on every one of these edges
      @(negedge clk);                        // Release away from the sampling edge
      reset = 1'b0;
   end

endmodule

`default_nettype wire

/* design/bif_dpath_ldbctl.sv */
/* Top of the local/bus data-path control block. Pins in, registered control
   outputs out, two clocks of latency through the decode PALs */
`timescale 1ns/1ps
`default_nettype none

module bif_dpath_ldbctl (
   input  logic                  clk,
   input  logic                  reset,
   input  ldbctl_pkg::ldb_pins_t pins,
   output ldbctl_pkg::ldb_out_t  ldb_out
);

   import ldbctl_pkg::*;

   wire ldb_sample_t smp;   // Sampled pins and taps
   wire ldb_ctl_t    ctl;   // Decoded results
   wire              bact;  // Bus active state

   bus_input_sync u_input (
      .clk   (clk),
      .reset (reset),
      .pins  (pins),
      .smp   (smp)
   );

   pal_44302b u_pal_ulbc1 (
      .clk       (clk),
      .reset     (reset),
      .smp       (smp),
      .bgnt_cact (ctl.bgnt_cact),
      .cgnt_cact (ctl.cgnt_cact),
      .emd       (ctl.emd),
      .dstb      (ctl.dstb)
   );

   pal_44303b u_pal_ulbc2 (
      .smp     (smp),
      .bact    (bact),
      .cbwrite (ctl.cbwrite),
      .wbd     (ctl.wbd),
      .wlbd    (ctl.wlbd)
   );

   pal_44304e u_pal_ulbc3 (
      .clk   (clk),
      .reset (reset),
      .smp   (smp),
      .bact  (bact),
      .dbapr (ctl.dbapr),
      .ebadr (ctl.ebadr),
      .ebd   (ctl.ebd),
      .clkbd (ctl.clkbd)
   );

   ldb_output_stage u_output (
      .clk     (clk),
      .reset   (reset),
      .ctl     (ctl),
      .ldb_out (ldb_out)
   );

endmodule

`default_nettype wire

/* design/ldb_output_stage.sv */
/* Output side. Blocks bus and local drive when both are asked for, converts the
   results to pin polarity and registers them */
`timescale 1ns/1ps
`default_nettype none

module ldb_output_stage (
   input  logic                  clk,
   input  logic                  reset,
   input  ldbctl_pkg::ldb_ctl_t  ctl,
   output ldbctl_pkg::ldb_out_t  ldb_out
);

   import ldbctl_pkg::*;

   logic     contention;  // Both directions requested
   ldb_out_t out_next;

   assign contention = ctl.wbd & ctl.wlbd;

   always_comb begin
      out_next.bgntcact   = ctl.bgnt_cact;             // Active high pin
      out_next.cgntcact_n = ~ctl.cgnt_cact;
      out_next.emd_n      = ~ctl.emd;
      out_next.dstb_n     = ~ctl.dstb;
      out_next.cbwrite_n  = ~ctl.cbwrite;
      out_next.wbd_n      = ~(ctl.wbd & ~contention);  // Off on contention
      out_next.wlbd_n     = ~(ctl.wlbd & ~contention);
      out_next.dbapr      = ctl.dbapr;
      out_next.ebadr      = ctl.ebadr;
      out_next.clkbd      = ctl.clkbd;
      out_next.ebd_n      = ~ctl.ebd;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         ldb_out <= LDB_OUT_RESET;   // All drivers inactive
      end else begin
         ldb_out <= out_next;
      end
   end

endmodule

`default_nettype wire

/* design/pal_44304e.sv */
/* Bus-active state, bus address/data enables and the bus-data clock. Bus active
   starts on a fresh bus grant and lasts until the grant drops */
`timescale 1ns/1ps
`default_nettype none

module pal_44304e (
   input  logic                    clk,
   input  logic                    reset,
   input  ldbctl_pkg::ldb_sample_t smp,
   output logic                    bact,
   output logic                    dbapr,
   output logic                    ebadr,
   output logic                    ebd,
   output logic                    clkbd
);

   logic new_grant;   // Grant present, old tap still clear
   logic bact_next;
   logic new_ack;     // Data acknowledge edge

   assign new_grant = smp.bgnt & ~smp.bgnt50;

   // Hold while granted, pd3 clears
   assign bact_next = ~smp.pd3 & smp.bgnt & (bact | new_grant);

   always_ff @(posedge clk) begin
      if (reset) begin
         bact <= 1'b0;                 // Bus idle
      end else begin
         bact <= bact_next;
      end
   end

   // Incoming address present, masked once data is acknowledged
   assign dbapr = smp.ibapr & ~smp.bdap50 & ~smp.cgnt;

   // CPU address onto the bus
   assign ebadr = smp.cgnt & smp.ebus & smp.gnt;

   // Data drivers for bus cycles or CPU-owned bus
   assign ebd   = bact | (smp.cgnt & smp.ebus);

   assign new_ack = smp.bdap & ~smp.bdap50;   // High for one cycle only

   // Latch bus data on acknowledge of a read
   assign clkbd = bact & ~smp.mwrite & new_ack;

endmodule

`default_nettype wire

/* design/pal_44303b.sv */
/* Write-cycle decode and bus/local direction enables. Combinational, fed by the
   sampled pins and the bus-active state from the bus-active PAL */
`timescale 1ns/1ps
`default_nettype none

module pal_44303b (
   input  ldbctl_pkg::ldb_sample_t smp,
   input  logic                    bact,
   output logic                    cbwrite,
   output logic                    wbd,
   output logic                    wlbd
);

   logic cbwrite_dec;  // CPU write onto the bus
   logic cmwrite;      // CPU write to local memory
   logic test_off;

   assign test_off = smp.pd1;  // Forces all enables low

   // CPU granted, address out, not an IO data cycle
   assign cbwrite_dec = smp.cact & smp.cgnt & smp.eadr & smp.write & ~smp.iod;

   // CPU active without grant, writes locally
   assign cmwrite = smp.cact & ~smp.cgnt & smp.write & ~smp.mis0;

   assign cbwrite = cbwrite_dec & ~test_off;

   // Bus direction for CPU bus writes or bus output cycles
   assign wbd  = ~test_off & (cbwrite_dec | (bact & ~smp.binput50));

   // Local direction for local writes or bus input cycles
   assign wlbd = ~test_off & (cmwrite | (bact & smp.binput50));

endmodule

`default_nettype wire

/* design/pal_44302b.sv */
/* Grant and CPU-active decode, memory data enable and the data strobe state.
   The strobe sets on a fresh bus ready and holds until terminate or retry */
`timescale 1ns/1ps
`default_nettype none

module pal_44302b (
   input  logic                    clk,
   input  logic                    reset,
   input  ldbctl_pkg::ldb_sample_t smp,
   output logic                    bgnt_cact,
   output logic                    cgnt_cact,
   output logic                    emd,
   output logic                    dstb
);

   logic bdry25;       // One-cycle sampled ready
   logic new_ready;    // Rising bus ready under bus grant
   logic hold_strobe;  // Strobe stays until cycle ends
   logic dstb_next;

   assign bdry25 = smp.bdry;

   // Which master owns the bus while the CPU is active
   assign bgnt_cact = smp.bgnt & smp.cact;
   assign cgnt_cact = smp.cgnt & smp.cact;

   // Memory data only on a settled CPU grant, never for IO
   assign emd = ~smp.pd3
              & smp.cgnt
              & smp.cgnt50          // Grant held at least a cycle
              & ~smp.iorq;

   // Ready edge seen as 25 set and 50 still clear
   assign new_ready   = smp.bgnt & bdry25 & ~smp.bdry50;

   // Terminate or retry ends the strobe
   assign hold_strobe = dstb & ~smp.term & ~smp.rt;

   // Test input kills the strobe outright
   assign dstb_next   = ~smp.pd3 & (new_ready | hold_strobe);

   always_ff @(posedge clk) begin
      if (reset) begin
         dstb <= 1'b0;               // Strobe off
      end else begin
         dstb <= dstb_next;
      end
   end

endmodule

`default_nettype wire

/* design/bus_input_sync.sv */
/* Input side. Registers the connector pins as active-high flags and keeps one older
   sample of the signals that the board used to pick off delay-line taps */
`timescale 1ns/1ps
`default_nettype none

module bus_input_sync (
   input  logic                    clk,
   input  logic                    reset,
   input  ldbctl_pkg::ldb_pins_t   pins,
   output ldbctl_pkg::ldb_sample_t smp
);

   always_ff @(posedge clk) begin
      if (reset) begin
         smp <= '0;                       // Everything inactive
      end else begin
         // First stage, pin level straight to active high
         smp.cact     <= ~pins.cact_n;
         smp.cgnt     <= ~pins.cgnt_n;
         smp.bgnt     <= ~pins.bgnt_n;
         smp.gnt      <= ~pins.gnt_n;
         smp.eadr     <= ~pins.eadr_n;
         smp.ebus     <= ~pins.ebus_n;
         smp.iod      <= ~pins.iod_n;
         smp.iorq     <= ~pins.iorq_n;
         smp.write    <= pins.write;      // Already active high
         smp.mwrite   <= ~pins.mwrite_n;
         smp.mis0     <= pins.mis0;       // Already active high
         smp.binput   <= ~pins.binput_n;
         smp.bdry     <= ~pins.bdry_n;    // 25 tap equivalent
         smp.bdap     <= ~pins.bdap_n;
         smp.term     <= ~pins.term_n;
         smp.rt       <= ~pins.rt_n;
         smp.ibapr    <= ~pins.ibapr_n;
         smp.pd1      <= pins.pd1;
         smp.pd3      <= pins.pd3;

         // Second stage stands in for the 50 taps
         smp.bdry50   <= smp.bdry;        // Previous bus ready
         smp.bgnt50   <= smp.bgnt;        // Previous bus grant
         smp.cgnt50   <= smp.cgnt;        // Previous CPU grant
         smp.binput50 <= smp.binput;      // Direction settled one cycle
         smp.bdap50   <= smp.bdap;        // Previous data acknowledge
      end
   end

endmodule

`default_nettype wire

/* design/ldbctl_pkg.sv */
/* Shared types for the local/bus data-path control block: pin, sample, result and output
   structs, plus the inactive output values loaded at reset */
`default_nettype none

package ldbctl_pkg;

   // Input pins as they arrive on the connector
   typedef struct packed {
      logic cact_n;    // CPU active
      logic cgnt_n;    // CPU granted the bus
      logic bgnt_n;    // Bus granted
      logic gnt_n;     // Any grant
      logic eadr_n;    // CPU address onto the bus
      logic ebus_n;    // Enable bus drivers
      logic iod_n;     // IO data cycle
      logic iorq_n;    // IO request
      logic write;     // CPU write
      logic mwrite_n;  // Memory write
      logic mis0;      // Microinstruction select 0
      logic binput_n;  // Bus input direction
      logic bdry_n;    // Bus data ready
      logic bdap_n;    // Bus data acknowledge
      logic term_n;    // Bus cycle terminate
      logic rt_n;      // Bus retry
      logic ibapr_n;   // Incoming bus address present
      logic pd1;       // Test input, direction enables off
      logic pd3;       // Test input, strobe and bus active off
   } ldb_pins_t;

   // Registered pins, all active high, with the delayed tap copies
   typedef struct packed {
      logic cact;
      logic cgnt;
      logic bgnt;
      logic gnt;
      logic eadr;
      logic ebus;
      logic iod;
      logic iorq;
      logic write;
      logic mwrite;
      logic mis0;
      logic binput;
      logic bdry;      // Also serves as the 25 tap
      logic bdap;
      logic term;
      logic rt;
      logic ibapr;
      logic pd1;
      logic pd3;
      logic bdry50;    // One sample older than bdry
      logic bgnt50;
      logic cgnt50;
      logic binput50;
      logic bdap50;
   } ldb_sample_t;

   // Decoded results from the three PALs, active high
   typedef struct packed {
      logic bgnt_cact;  // Bus granted while CPU active
      logic cgnt_cact;  // CPU granted while CPU active
      logic emd;        // Enable memory data
      logic dstb;       // Data strobe
      logic cbwrite;    // CPU write cycle to bus
      logic wbd;        // Write bus direction
      logic wlbd;       // Write local bus direction
      logic dbapr;      // Delayed bus address present
      logic ebadr;      // Enable bus address
      logic clkbd;      // Clock bus data
      logic ebd;        // Enable bus data
   } ldb_ctl_t;

   // Same results at pin polarity
   typedef struct packed {
      logic bgntcact;
      logic cgntcact_n;
      logic emd_n;
      logic dstb_n;
      logic cbwrite_n;
      logic wbd_n;
      logic wlbd_n;
      logic dbapr;
      logic ebadr;
      logic clkbd;
      logic ebd_n;
   } ldb_out_t;

   // Every output driven to its inactive level
   localparam ldb_out_t LDB_OUT_RESET = '{
      bgntcact:   1'b0,
      cgntcact_n: 1'b1,
      emd_n:      1'b1,
      dstb_n:     1'b1,
      cbwrite_n:  1'b1,
      wbd_n:      1'b1,
      wlbd_n:     1'b1,
      dbapr:      1'b0,
      ebadr:      1'b0,
      clkbd:      1'b0,
      ebd_n:      1'b1
   };

endpackage

`default_nettype wire
